// ==== Makefile ====
# Verilator flow for the dual-clock stream merge

TOP = merge_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

# pass only when the run prints the pass line
sim:
	verilator --binary --timing -j 0 -f sim.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir

// ==== include/stream_config.svh ====
/* stream merge configuration */

`ifndef STREAM_CONFIG_SVH
`define STREAM_CONFIG_SVH

// width of one data word
`define STREAM_DATA_WIDTH 64

// one keep bit per data byte
`define STREAM_KEEP_WIDTH (`STREAM_DATA_WIDTH / 8)

// log2 of fifo depth, 16 entries by default
`define FIFO_ADDR_WIDTH 4

`endif

// ==== sim.f ====
+incdir+include
src/stream_pkg.sv
src/axis_async_fifo.sv
src/frame_arbiter.sv
src/dual_clock_merge_top.sv
test/merge_tb.sv

// ==== src/axis_async_fifo.sv ====
/* dual-clock stream FIFO */

`include "stream_config.svh"

module axis_async_fifo #(
    parameter int ADDR_WIDTH = `FIFO_ADDR_WIDTH
) (
    // write side
    input  logic                     in_clk,
    input  logic                     in_rst,
    input  stream_pkg::stream_data_t in_tdata,
    input  stream_pkg::stream_keep_t in_tkeep,
    input  logic                     in_tlast,
    input  logic                     in_tuser,
    input  logic                     in_tvalid,
    output logic                     in_tready,

    // read side
    input  logic                     output_clk,
    input  logic                     output_rst_sync2,
    output stream_pkg::stream_data_t out_tdata,
    output stream_pkg::stream_keep_t out_tkeep,
    output logic                     out_tlast,
    output logic                     out_tuser,
    output logic                     out_tvalid,
    input  logic                     out_tready
);
    import stream_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;
    // last, user, keep and data packed together
    localparam int BEAT_WIDTH = $bits(stream_data_t) + $bits(stream_keep_t) + 2;

    // local reset synchronizers
    logic wr_rst_sync1;
    logic wr_rst_sync2;
    logic rd_rst_sync1;
    logic rd_rst_sync2;

    // beat storage
    logic [BEAT_WIDTH-1:0] mem [DEPTH];
    logic [BEAT_WIDTH-1:0] wr_beat;
    logic [BEAT_WIDTH-1:0] out_beat;

    // write pointer, binary plus gray copy, one wrap bit
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] wr_ptr_next;
    logic [ADDR_WIDTH:0] wr_ptr_gray;
    logic [ADDR_WIDTH:0] wr_ptr_gray_next;

    // read pointer, next entry to load into the output register
    logic [ADDR_WIDTH:0] rd_ptr;
    logic [ADDR_WIDTH:0] rd_ptr_next;
    logic [ADDR_WIDTH:0] rd_ptr_gray;
    logic [ADDR_WIDTH:0] rd_ptr_gray_next;

    // release pointer, advances as beats leave the output register
    logic [ADDR_WIDTH:0] rel_ptr;
    logic [ADDR_WIDTH:0] rel_ptr_next;
    logic [ADDR_WIDTH:0] rel_ptr_gray;
    logic [ADDR_WIDTH:0] rel_ptr_gray_next;

    // gray pointers after crossing
    logic [ADDR_WIDTH:0] rd_gray_sync1;
    logic [ADDR_WIDTH:0] rd_gray_sync2;
    logic [ADDR_WIDTH:0] wr_gray_sync1;
    logic [ADDR_WIDTH:0] wr_gray_sync2;

    logic wr_up;
    logic full;
    logic empty;
    logic write;
    logic read;
    logic take;
    logic out_valid_reg;

    // write-side reset, asserted by either domain's reset
    always_ff @(posedge in_clk or posedge in_rst or posedge output_rst_sync2) begin
        if (in_rst || output_rst_sync2) begin
            wr_rst_sync1 <= 1'b1;
            wr_rst_sync2 <= 1'b1;
        end else begin
            wr_rst_sync1 <= 1'b0;
            wr_rst_sync2 <= wr_rst_sync1;
        end
    end

    // read-side reset, input reset brought into output_clk
    always_ff @(posedge output_clk or posedge in_rst or posedge output_rst_sync2) begin
        if (in_rst || output_rst_sync2) begin
            rd_rst_sync1 <= 1'b1;
            rd_rst_sync2 <= 1'b1;
        end else begin
            rd_rst_sync1 <= 1'b0;
            rd_rst_sync2 <= rd_rst_sync1;
        end
    end

    assign wr_beat = {in_tlast, in_tuser, in_tkeep, in_tdata};

    assign wr_ptr_next       = wr_ptr + {{ADDR_WIDTH{1'b0}}, 1'b1};
    assign wr_ptr_gray_next  = wr_ptr_next ^ (wr_ptr_next >> 1);
    assign rd_ptr_next       = rd_ptr + {{ADDR_WIDTH{1'b0}}, 1'b1};
    assign rd_ptr_gray_next  = rd_ptr_next ^ (rd_ptr_next >> 1);
    assign rel_ptr_next      = rel_ptr + {{ADDR_WIDTH{1'b0}}, 1'b1};
    assign rel_ptr_gray_next = rel_ptr_next ^ (rel_ptr_next >> 1);

    // full: top two gray bits inverted, rest equal
    // beat held in the output register still counts
    assign full = (wr_ptr_gray[ADDR_WIDTH:ADDR_WIDTH-1] == ~rd_gray_sync2[ADDR_WIDTH:ADDR_WIDTH-1])
               && (wr_ptr_gray[ADDR_WIDTH-2:0] == rd_gray_sync2[ADDR_WIDTH-2:0]);
    // empty on exact match
    assign empty = (rd_ptr_gray == wr_gray_sync2);

    // ready held low until the write side leaves reset
    assign in_tready = wr_up && !full;
    assign write     = in_tvalid && in_tready;

    // refill the output register when free or being taken
    assign read = !empty && (!out_valid_reg || out_tready);
    assign take = out_valid_reg && out_tready;

    // write into storage
    always_ff @(posedge in_clk) begin
        if (write) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr_beat;
        end
    end

    // write pointer advance
    always_ff @(posedge in_clk or posedge wr_rst_sync2) begin
        if (wr_rst_sync2) begin
            wr_ptr      <= '0;
            wr_ptr_gray <= '0;
            wr_up       <= 1'b0;
        end else begin
            wr_up <= 1'b1;
            if (write) begin
                wr_ptr      <= wr_ptr_next;
                wr_ptr_gray <= wr_ptr_gray_next;
            end
        end
    end

    // release pointer into write domain
    always_ff @(posedge in_clk or posedge wr_rst_sync2) begin
        if (wr_rst_sync2) begin
            rd_gray_sync1 <= '0;
            rd_gray_sync2 <= '0;
        end else begin
            rd_gray_sync1 <= rel_ptr_gray;
            rd_gray_sync2 <= rd_gray_sync1;
        end
    end

    // write pointer into read domain
    always_ff @(posedge output_clk or posedge rd_rst_sync2) begin
        if (rd_rst_sync2) begin
            wr_gray_sync1 <= '0;
            wr_gray_sync2 <= '0;
        end else begin
            wr_gray_sync1 <= wr_ptr_gray;
            wr_gray_sync2 <= wr_gray_sync1;
        end
    end

    // read pointer advance
    always_ff @(posedge output_clk or posedge rd_rst_sync2) begin
        if (rd_rst_sync2) begin
            rd_ptr      <= '0;
            rd_ptr_gray <= '0;
        end else if (read) begin
            rd_ptr      <= rd_ptr_next;
            rd_ptr_gray <= rd_ptr_gray_next;
        end
    end

    // slot freed once its beat leaves the output register
    always_ff @(posedge output_clk or posedge rd_rst_sync2) begin
        if (rd_rst_sync2) begin
            rel_ptr      <= '0;
            rel_ptr_gray <= '0;
        end else if (take) begin
            rel_ptr      <= rel_ptr_next;
            rel_ptr_gray <= rel_ptr_gray_next;
        end
    end

    // output register payload
    always_ff @(posedge output_clk) begin
        if (read) begin
            out_beat <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    // output valid follows whether a beat was loaded
    always_ff @(posedge output_clk or posedge rd_rst_sync2) begin
        if (rd_rst_sync2) begin
            out_valid_reg <= 1'b0;
        end else if (!out_valid_reg || out_tready) begin
            out_valid_reg <= !empty;
        end
    end

    assign {out_tlast, out_tuser, out_tkeep, out_tdata} = out_beat;
    assign out_tvalid = out_valid_reg;

endmodule

// ==== src/dual_clock_merge_top.sv ====
/* dual-clock two-port stream merge */

module dual_clock_merge_top (
    // port a, a_clk domain
    input  logic                     a_clk,
    input  logic                     a_rst,
    input  stream_pkg::stream_data_t a_tdata,
    input  stream_pkg::stream_keep_t a_tkeep,
    input  logic                     a_tlast,
    input  logic                     a_tuser,
    input  logic                     a_tvalid,
    output logic                     a_tready,

    // port b, b_clk domain
    input  logic                     b_clk,
    input  logic                     b_rst,
    input  stream_pkg::stream_data_t b_tdata,
    input  stream_pkg::stream_keep_t b_tkeep,
    input  logic                     b_tlast,
    input  logic                     b_tuser,
    input  logic                     b_tvalid,
    output logic                     b_tready,

    // merged output, output_clk domain
    input  logic                     output_clk,
    input  logic                     output_rst_sync2,
    output stream_pkg::stream_data_t out_tdata,
    output stream_pkg::stream_keep_t out_tkeep,
    output logic                     out_tlast,
    output logic                     out_tuser,
    output stream_pkg::src_id_t      out_tsrc,
    output logic                     out_tvalid,
    input  logic                     out_tready
);
    import stream_pkg::*;

    // fifo a to arbiter
    stream_data_t fa_tdata;
    stream_keep_t fa_tkeep;
    logic         fa_tlast;
    logic         fa_tuser;
    logic         fa_tvalid;
    logic         fa_tready;

    // fifo b to arbiter
    stream_data_t fb_tdata;
    stream_keep_t fb_tkeep;
    logic         fb_tlast;
    logic         fb_tuser;
    logic         fb_tvalid;
    logic         fb_tready;

    // port a crossing
    axis_async_fifo u_fifo_a (
        .in_clk           (a_clk),
        .in_rst           (a_rst),
        .in_tdata         (a_tdata),
        .in_tkeep         (a_tkeep),
        .in_tlast         (a_tlast),
        .in_tuser         (a_tuser),
        .in_tvalid        (a_tvalid),
        .in_tready        (a_tready),
        .output_clk       (output_clk),
        .output_rst_sync2 (output_rst_sync2),
        .out_tdata        (fa_tdata),
        .out_tkeep        (fa_tkeep),
        .out_tlast        (fa_tlast),
        .out_tuser        (fa_tuser),
        .out_tvalid       (fa_tvalid),
        .out_tready       (fa_tready)
    );

    // port b crossing
    axis_async_fifo u_fifo_b (
        .in_clk           (b_clk),
        .in_rst           (b_rst),
        .in_tdata         (b_tdata),
        .in_tkeep         (b_tkeep),
        .in_tlast         (b_tlast),
        .in_tuser         (b_tuser),
        .in_tvalid        (b_tvalid),
        .in_tready        (b_tready),
        .output_clk       (output_clk),
        .output_rst_sync2 (output_rst_sync2),
        .out_tdata        (fb_tdata),
        .out_tkeep        (fb_tkeep),
        .out_tlast        (fb_tlast),
        .out_tuser        (fb_tuser),
        .out_tvalid       (fb_tvalid),
        .out_tready       (fb_tready)
    );

    // frame merge in the output domain
    frame_arbiter u_arb (
        .output_clk       (output_clk),
        .output_rst_sync2 (output_rst_sync2),
        .fa_tdata         (fa_tdata),
        .fa_tkeep         (fa_tkeep),
        .fa_tlast         (fa_tlast),
        .fa_tuser         (fa_tuser),
        .fa_tvalid        (fa_tvalid),
        .fa_tready        (fa_tready),
        .fb_tdata         (fb_tdata),
        .fb_tkeep         (fb_tkeep),
        .fb_tlast         (fb_tlast),
        .fb_tuser         (fb_tuser),
        .fb_tvalid        (fb_tvalid),
        .fb_tready        (fb_tready),
        .out_tdata        (out_tdata),
        .out_tkeep        (out_tkeep),
        .out_tlast        (out_tlast),
        .out_tuser        (out_tuser),
        .out_tsrc         (out_tsrc),
        .out_tvalid       (out_tvalid),
        .out_tready       (out_tready)
    );

endmodule

// ==== src/frame_arbiter.sv ====
/* frame-atomic two-way stream merge */

module frame_arbiter (
    input  logic                     output_clk,
    input  logic                     output_rst_sync2,

    // source a, from fifo a
    input  stream_pkg::stream_data_t fa_tdata,
    input  stream_pkg::stream_keep_t fa_tkeep,
    input  logic                     fa_tlast,
    input  logic                     fa_tuser,
    input  logic                     fa_tvalid,
    output logic                     fa_tready,

    // source b, from fifo b
    input  stream_pkg::stream_data_t fb_tdata,
    input  stream_pkg::stream_keep_t fb_tkeep,
    input  logic                     fb_tlast,
    input  logic                     fb_tuser,
    input  logic                     fb_tvalid,
    output logic                     fb_tready,

    // merged stream
    output stream_pkg::stream_data_t out_tdata,
    output stream_pkg::stream_keep_t out_tkeep,
    output logic                     out_tlast,
    output logic                     out_tuser,
    output stream_pkg::src_id_t      out_tsrc,
    output logic                     out_tvalid,
    input  logic                     out_tready
);
    import stream_pkg::*;

    // held grant while a frame is open
    src_id_t grant_src;
    logic    grant_active;
    // source of the last finished frame
    src_id_t last_src;

    src_id_t pick_src;
    src_id_t cur_src;
    logic    xfer;

    // idle choice, round robin when both wait
    always_comb begin
        if (fa_tvalid && fb_tvalid) begin
            if (last_src == SRC_A) begin
                pick_src = SRC_B;
            end else begin
                pick_src = SRC_A;
            end
        end else if (fb_tvalid) begin
            pick_src = SRC_B;
        end else begin
            pick_src = SRC_A;
        end
    end

    // locked grant wins over a fresh pick
    always_comb begin
        if (grant_active) begin
            cur_src = grant_src;
        end else begin
            cur_src = pick_src;
        end
    end

    // data path mux, no register
    always_comb begin
        if (cur_src == SRC_B) begin
            out_tdata  = fb_tdata;
            out_tkeep  = fb_tkeep;
            out_tlast  = fb_tlast;
            out_tuser  = fb_tuser;
            out_tvalid = fb_tvalid;
        end else begin
            out_tdata  = fa_tdata;
            out_tkeep  = fa_tkeep;
            out_tlast  = fa_tlast;
            out_tuser  = fa_tuser;
            out_tvalid = fa_tvalid;
        end
    end

    assign out_tsrc = cur_src;

    // only the selected fifo sees ready
    assign fa_tready = out_tready && (cur_src == SRC_A);
    assign fb_tready = out_tready && (cur_src == SRC_B);

    assign xfer = out_tvalid && out_tready;

    // lock on any presented beat so a stalled beat stays put
    // release after the last beat of the frame moves
    always_ff @(posedge output_clk or posedge output_rst_sync2) begin
        if (output_rst_sync2) begin
            grant_active <= 1'b0;
            grant_src    <= SRC_A;
            last_src     <= SRC_B;
        end else if (out_tvalid) begin
            grant_src <= cur_src;
            if (xfer && out_tlast) begin
                grant_active <= 1'b0;
                last_src     <= cur_src;
            end else begin
                grant_active <= 1'b1;
            end
        end
    end

endmodule

// ==== src/stream_pkg.sv ====
/* stream merge types */

`include "stream_config.svh"

package stream_pkg;

    // one data word of a beat
    typedef logic [`STREAM_DATA_WIDTH-1:0] stream_data_t;

    // byte keep vector, bit n qualifies byte n
    typedef logic [`STREAM_KEEP_WIDTH-1:0] stream_keep_t;

    // input port a merged beat came from
    typedef enum logic {
        SRC_A = 1'b0,
        SRC_B = 1'b1
    } src_id_t;

endpackage

// ==== test/merge_tb.sv ====
/* dual-clock merge testbench */

`include "stream_config.svh"

module merge_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import stream_pkg::*;

    localparam int TIMEOUT = 2000;

    typedef struct packed {
        stream_data_t data;
        stream_keep_t keep;
        logic         last;
        logic         user;
    } beat_t;

    logic         output_clk = 1'b0;
    logic         a_clk = 1'b0;
    logic         b_clk = 1'b0;
    logic         output_rst_sync2 = 1'b1;
    logic         a_rst = 1'b1;
    logic         b_rst = 1'b1;
    stream_data_t a_tdata = '0;
    stream_keep_t a_tkeep = '0;
    logic         a_tlast = 1'b0;
    logic         a_tuser = 1'b0;
    logic         a_tvalid = 1'b0;
    logic         a_tready;
    stream_data_t b_tdata = '0;
    stream_keep_t b_tkeep = '0;
    logic         b_tlast = 1'b0;
    logic         b_tuser = 1'b0;
    logic         b_tvalid = 1'b0;
    logic         b_tready;
    stream_data_t out_tdata;
    stream_keep_t out_tkeep;
    logic         out_tlast;
    logic         out_tuser;
    src_id_t      out_tsrc;
    logic         out_tvalid;
    logic         out_tready = 1'b1;

    // expected beats per source, in send order
    beat_t   exp_a[$];
    beat_t   exp_b[$];
    beat_t   cur_a;
    beat_t   cur_b;
    integer  seed;
    int      errors = 0;
    int      checks = 0;
    int      tests = 0;
    // monitor frame state
    logic    in_frame = 1'b0;
    src_id_t frame_src = SRC_A;
    src_id_t prev_src = SRC_A;
    logic    has_prev = 1'b0;
    logic    alt_check = 1'b0;
    logic    bp_run = 1'b0;

    dual_clock_merge_top dut (.*);

    // 10 ns output, 14 ns port a, 8 ns port b
    always #5 output_clk = ~output_clk;
    always #7 a_clk = ~a_clk;
    always #4 b_clk = ~b_clk;

    task automatic check_data(input string name, input stream_data_t got, input stream_data_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_keep(input string name, input stream_keep_t got, input stream_keep_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, want);
        end
    endtask

    task automatic check_src(input string name, input src_id_t got, input src_id_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %0t %s got %s expected %s", $time, name, got.name(), want.name());
        end
    endtask

    // random payload, partial keep only on the closing beat
    function automatic beat_t new_beat(input logic last);
        beat_t b;
        int    r;
        b.data = {$random(seed), $random(seed)};
        r = $random(seed);
        b.keep = last ? (stream_keep_t'(r) | stream_keep_t'(1)) : '1;
        b.last = last;
        b.user = last & r[8];
        return b;
    endfunction

    task automatic drive_a(input beat_t b);
        @(negedge a_clk);
        a_tdata = b.data;
        a_tkeep = b.keep;
        a_tlast = b.last;
        a_tuser = b.user;
        a_tvalid = 1'b1;
        cur_a = b;
    endtask

    task automatic drive_b(input beat_t b);
        @(negedge b_clk);
        b_tdata = b.data;
        b_tkeep = b.keep;
        b_tlast = b.last;
        b_tuser = b.user;
        b_tvalid = 1'b1;
        cur_b = b;
    endtask

    // beat counts as sent on the edge where ready is seen high
    task automatic wait_accept_a(input int limit, output logic ok);
        int n;
        ok = 1'b0;
        n = 0;
        while (!ok && n < limit) begin
            @(posedge a_clk);
            ok = a_tready;
            n++;
        end
        if (ok) exp_a.push_back(cur_a);
    endtask

    task automatic wait_accept_b(input int limit, output logic ok);
        int n;
        ok = 1'b0;
        n = 0;
        while (!ok && n < limit) begin
            @(posedge b_clk);
            ok = b_tready;
            n++;
        end
        if (ok) exp_b.push_back(cur_b);
    endtask

    task automatic idle_port(input src_id_t src);
        if (src == SRC_A) begin
            @(negedge a_clk);
            a_tvalid = 1'b0;
        end else begin
            @(negedge b_clk);
            b_tvalid = 1'b0;
        end
    endtask

    task automatic send_frame(input src_id_t src, input int len);
        beat_t b;
        logic  ok;
        for (int i = 0; i < len; i++) begin
            b = new_beat(i == len - 1);
            if (src == SRC_A) begin
                drive_a(b);
                wait_accept_a(TIMEOUT, ok);
            end else begin
                drive_b(b);
                wait_accept_b(TIMEOUT, ok);
            end
            if (!ok) begin
                errors++;
                $display("port %s did not accept beat %0d in %0d cycles", src.name(), i, TIMEOUT);
            end
        end
    endtask

    // frames of 2 to 5 beats, back to back
    task automatic send_frames(input src_id_t src, input int count);
        for (int f = 0; f < count; f++) begin
            send_frame(src, 2 + int'({$random(seed)} % 4));
        end
        idle_port(src);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_a.size() > 0 || exp_b.size() > 0) && n < TIMEOUT) begin
            @(posedge output_clk);
            n++;
        end
        if (exp_a.size() > 0 || exp_b.size() > 0) begin
            errors++;
            $display("%0d beats of a and %0d of b never came out", exp_a.size(), exp_b.size());
        end
    endtask

    task automatic report_test(input string name, input int e0);
        tests++;
        $display("test %s finished with %0d errors", name, errors - e0);
    endtask

    // one output transfer, checked against its source queue
    task automatic take_beat();
        beat_t want;
        logic  none;
        if (in_frame) begin
            check_src("out_tsrc", out_tsrc, frame_src);
        end else if (alt_check && has_prev && exp_a.size() > 0 && exp_b.size() > 0) begin
            // both pending so the other source is due
            check_src("out_tsrc", out_tsrc, prev_src == SRC_A ? SRC_B : SRC_A);
        end
        none = (out_tsrc == SRC_A) ? (exp_a.size() == 0) : (exp_b.size() == 0);
        if (none) begin
            errors++;
            $display("beat tagged %s came out with none outstanding", out_tsrc.name());
        end else begin
            if (out_tsrc == SRC_A) want = exp_a.pop_front();
            else want = exp_b.pop_front();
            check_data("out_tdata", out_tdata, want.data);
            check_keep("out_tkeep", out_tkeep, want.keep);
            check_flag("out_tlast", out_tlast, want.last);
            check_flag("out_tuser", out_tuser, want.user);
        end
        in_frame = !out_tlast;
        frame_src = out_tsrc;
        if (out_tlast) begin
            has_prev = 1'b1;
            prev_src = out_tsrc;
        end
    endtask

    always @(posedge output_clk) begin
        if (!output_rst_sync2 && out_tvalid && out_tready) take_beat();
    end

    task automatic test_reset();
        int e0;
        int n;
        e0 = errors;
        n = 0;
        check_flag("out_tvalid", out_tvalid, 1'b0);
        while (!(a_tready && b_tready) && n < TIMEOUT) begin
            @(posedge output_clk);
            n++;
        end
        if (!(a_tready && b_tready)) begin
            errors++;
            $display("input ready did not rise after reset");
        end
        report_test("reset", e0);
    endtask

    task automatic test_single();
        int e0;
        e0 = errors;
        send_frame(SRC_A, 5);
        idle_port(SRC_A);
        wait_drain();
        send_frame(SRC_B, 3);
        idle_port(SRC_B);
        wait_drain();
        report_test("single source", e0);
    endtask

    task automatic test_alternate();
        int e0;
        int n;
        e0 = errors;
        n = 0;
        @(negedge output_clk);
        out_tready = 1'b0;
        fork
            send_frames(SRC_A, 3);
            send_frames(SRC_B, 3);
        join
        while (!(dut.fa_tvalid && dut.fb_tvalid) && n < TIMEOUT) begin
            @(posedge output_clk);
            n++;
        end
        if (!(dut.fa_tvalid && dut.fb_tvalid)) begin
            errors++;
            $display("loaded frames never reached the arbiter");
        end
        // pointer sync and output register settle
        repeat (4) @(posedge output_clk);
        has_prev = 1'b0;
        alt_check = 1'b1;
        @(negedge output_clk);
        out_tready = 1'b1;
        wait_drain();
        alt_check = 1'b0;
        report_test("alternation", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        int n;
        int r;
        e0 = errors;
        n = 0;
        bp_run = 1'b1;
        fork
            begin
                fork
                    send_frames(SRC_A, 4);
                    send_frames(SRC_B, 4);
                join
                bp_run = 1'b0;
            end
            while (bp_run && n < 4 * TIMEOUT) begin
                @(negedge output_clk);
                r = $random(seed);
                out_tready = r[0];
                n++;
            end
        join
        @(negedge output_clk);
        out_tready = 1'b1;
        wait_drain();
        report_test("back-pressure", e0);
    endtask

    task automatic test_fill();
        int   e0;
        int   taken;
        int   cap;
        logic ok;
        e0 = errors;
        taken = 0;
        // one beat per fifo entry
        cap = 1 << `FIFO_ADDR_WIDTH;
        @(negedge output_clk);
        out_tready = 1'b0;
        for (int i = 0; i < cap; i++) begin
            drive_a(new_beat(i == cap - 1));
            wait_accept_a(TIMEOUT, ok);
            if (ok) taken++;
        end
        // full, one more beat stalls
        drive_a(new_beat(1'b1));
        wait_accept_a(40, ok);
        check_flag("a_tready", ok, 1'b0);
        if (taken != cap) begin
            errors++;
            $display("port a took %0d beats while stalled instead of %0d", taken, cap);
        end
        @(negedge output_clk);
        out_tready = 1'b1;
        wait_accept_a(TIMEOUT, ok);
        if (!ok) begin
            errors++;
            $display("port a stayed stalled after the output was released");
        end
        idle_port(SRC_A);
        wait_drain();
        report_test("fill and stall", e0);
    endtask

    initial begin
        seed = 32'h2fb8;
        repeat (10) @(posedge output_clk);
        @(negedge output_clk);
        output_rst_sync2 = 1'b0;
        a_rst = 1'b0;
        b_rst = 1'b0;
        test_reset();
        test_single();
        test_alternate();
        test_backpressure();
        test_fill();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
